/* hw/pad_pkg.sv */
//////////////////////////////
// Pad kinds, pad attributes and pad-side drive bundle
// Default MIO pad count
//////////////////////////////

`default_nettype none

package pad_pkg;

  // Pad cell variants, encoded as in the pad frame
  typedef enum logic [1:0] {
    PadBidir     = 2'd0,
    PadInputOnly = 2'd1,
    PadTolerant  = 2'd2,
    PadOpenDrain = 2'd3
  } pad_variant_e;

  // Per-pad attribute, written by the core
  typedef struct packed {
    logic invert;     // Flip both directions
    logic virt_od_en; // Emulated open drain
    logic pull_en;
    logic pull_up;    // 1 = pull up, 0 = pull down
  } pad_attr_t;

  // What the pad driver sees
  typedef struct packed {
    logic out;
    logic oe;
    logic pull_en;
    logic pull_up;
  } pad_drive_t;

  // Strap positions need at least 9 MIO pads
  parameter int unsigned DefaultNumMio = 12;

endpackage : pad_pkg

`default_nettype wire

/* hw/pinout_pkg.sv */
//////////////////////////////
// DIO pin map, strap and JTAG positions
// TAP select, strap and JTAG request types
//////////////////////////////

`default_nettype none

package pinout_pkg;

  parameter int unsigned NumDio = 9;

  // Dedicated pads
  parameter int unsigned DioUsbN        = 0;
  parameter int unsigned DioUsbP        = 1;
  parameter int unsigned DioUsbD        = 2; // Fed by the differential receiver
  parameter int unsigned DioUsbDpPullup = 3;
  parameter int unsigned DioUsbDnPullup = 4;
  parameter int unsigned DioSpiDevD0    = 5; // TDI
  parameter int unsigned DioSpiDevD1    = 6; // TDO
  parameter int unsigned DioSpiDevCsb   = 7; // TMS
  parameter int unsigned DioSpiDevSck   = 8; // TCK

  // MIO positions of straps and TRST
  parameter int unsigned DftStrap0Idx = 4;
  parameter int unsigned DftStrap1Idx = 5;
  parameter int unsigned TrstIdx      = 6;
  parameter int unsigned TapStrap1Idx = 7;
  parameter int unsigned TapStrap0Idx = 8;

  // CSB is active low, so it idles high while the TAP owns the pins
  parameter logic [NumDio-1:0] JtagTieOff = NumDio'(1) << DioSpiDevCsb;

  typedef enum logic [1:0] {
    TapNone = 2'd0,
    TapLc   = 2'd1,
    TapRv   = 2'd2,
    TapDft  = 2'd3
  } tap_sel_e;

  typedef struct packed {
    logic       valid;
    tap_sel_e   tap;
    logic [1:0] dft;
  } strap_t;

  typedef struct packed {
    logic tck;
    logic tms;
    logic tdi;
    logic trst_n;
  } jtag_req_t;

endpackage : pinout_pkg

`default_nettype wire

/* hw/pad_cell.sv */
//////////////////////////////
// Single pad cell model
//////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module pad_cell
  import pad_pkg::*;
#(
  parameter pad_variant_e Variant = PadBidir
) (
  input  logic       out_i,
  input  logic       oe_i,
  input  pad_attr_t  attr_i,
  input  logic       pad_i,
  output pad_drive_t pad_o,
  output logic       in_o
);

  logic out_val;
  logic oe_val;

  assign out_val = out_i ^ attr_i.invert;

  // Enable resolution per variant, fixed at elaboration
  if (Variant == PadInputOnly) begin : gen_input_only
    assign oe_val = 1'b0;          // No driver in this cell
  end else if (Variant == PadOpenDrain) begin : gen_open_drain
    // Only ever pulls low, which also covers virtual open drain
    assign oe_val = oe_i & ~out_val;
  end else begin : gen_push_pull
    assign oe_val = oe_i & ~(attr_i.virt_od_en & out_val);
  end

  assign pad_o = '{
    out:     out_val,
    oe:      oe_val,
    pull_en: attr_i.pull_en,
    pull_up: attr_i.pull_up
  };

  // Input side sees the same inversion
  assign in_o = pad_i ^ attr_i.invert;

endmodule : pad_cell

`default_nettype wire

/* hw/padring.sv */
//////////////////////////////
// Pad ring with one cell per MIO and DIO pad
//////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module padring
  import pad_pkg::*;
  import pinout_pkg::*;
#(
  parameter int unsigned                NumMio        = DefaultNumMio,
  parameter pad_variant_e [NumMio-1:0] MioPadVariant = '{default: PadBidir},
  parameter pad_variant_e [NumDio-1:0] DioPadVariant = '{default: PadBidir}
) (
  // Muxed pads
  input  logic       [NumMio-1:0] mio_out_i,
  input  logic       [NumMio-1:0] mio_oe_i,
  input  pad_attr_t  [NumMio-1:0] mio_attr_i,
  input  logic       [NumMio-1:0] mio_pad_i,
  output pad_drive_t [NumMio-1:0] mio_pad_o,
  output logic       [NumMio-1:0] mio_in_o,
  // Dedicated pads
  input  logic       [NumDio-1:0] dio_out_i,
  input  logic       [NumDio-1:0] dio_oe_i,
  input  pad_attr_t  [NumDio-1:0] dio_attr_i,
  input  logic       [NumDio-1:0] dio_pad_i,
  output pad_drive_t [NumDio-1:0] dio_pad_o,
  output logic       [NumDio-1:0] dio_in_o
);

  //////////////////////////////
  // MIO pads
  //////////////////////////////

  for (genvar i = 0; i < NumMio; i++) begin : gen_mio
    pad_cell #(
      .Variant ( MioPadVariant[i] )
    ) mio_pad_inst (
      .out_i   ( mio_out_i[i]  ),
      .oe_i    ( mio_oe_i[i]   ),
      .attr_i  ( mio_attr_i[i] ),
      .pad_i   ( mio_pad_i[i]  ),
      .pad_o   ( mio_pad_o[i]  ),
      .in_o    ( mio_in_o[i]   )
    );
  end

  //////////////////////////////
  // DIO pads
  //////////////////////////////

  for (genvar i = 0; i < NumDio; i++) begin : gen_dio
    pad_cell #(
      .Variant ( DioPadVariant[i] )
    ) dio_pad_inst (
      .out_i   ( dio_out_i[i]  ),
      .oe_i    ( dio_oe_i[i]   ),
      .attr_i  ( dio_attr_i[i] ),
      .pad_i   ( dio_pad_i[i]  ),
      .pad_o   ( dio_pad_o[i]  ),
      .in_o    ( dio_in_o[i]   )
    );
  end

endmodule : padring

`default_nettype wire

/* hw/strap_sampler.sv */
//////////////////////////////
// One-shot TAP and DFT strap capture after reset
//////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module strap_sampler
  import pad_pkg::*;
  import pinout_pkg::*;
#(
  parameter int unsigned NumMio = DefaultNumMio
) (
  input  logic              clk_main_i,
  input  logic              rst_i,
  input  logic [NumMio-1:0] mio_sync_i,
  output strap_t            strap_o
);

  // Synchronizer needs two edges before the straps are settled
  localparam logic [1:0] CaptureCnt = 2'd2;

  logic [1:0] cnt_q;
  strap_t     strap_q;

  always_ff @(posedge clk_main_i) begin
    if (rst_i) begin
      cnt_q   <= '0;
      strap_q <= '0;
    end else if (!strap_q.valid) begin
      if (cnt_q == CaptureCnt) begin // Third edge out of reset
        strap_q.valid <= 1'b1;
        strap_q.tap   <= tap_sel_e'({mio_sync_i[TapStrap1Idx], mio_sync_i[TapStrap0Idx]});
        strap_q.dft   <= {mio_sync_i[DftStrap1Idx], mio_sync_i[DftStrap0Idx]};
      end else begin
        cnt_q <= cnt_q + 2'd1;
      end
    end
  end

  assign strap_o = strap_q; // Held until the next reset

endmodule : strap_sampler

`default_nettype wire

/* hw/io_overlay.sv */
//////////////////////////////
// Input synchronizer between pad ring and core
// JTAG pin takeover and USB receive overlay
//////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module io_overlay
  import pad_pkg::*;
  import pinout_pkg::*;
#(
  parameter int unsigned NumMio = DefaultNumMio
) (
  input  logic              clk_main_i,
  input  logic              rst_i,
  // Core outputs
  input  logic [NumDio-1:0] dio_out_i,
  input  logic [NumDio-1:0] dio_oe_i,
  // From the ring and the raw pads
  input  logic [NumMio-1:0] mio_ring_i,
  input  logic [NumDio-1:0] dio_ring_i,
  input  logic [NumDio-1:0] dio_pad_i,
  input  strap_t            strap_i,
  input  logic              usb_rx_en_i,
  input  logic              jtag_tdo_i,
  // To the ring
  output logic [NumDio-1:0] dio_out_o,
  output logic [NumDio-1:0] dio_oe_o,
  // To the core
  output logic [NumMio-1:0] mio_in_o,
  output logic [NumDio-1:0] dio_in_o,
  output logic [NumMio-1:0] mio_sync_o,
  output logic              usb_pullup_dp_o,
  output logic              usb_pullup_dn_o,
  output jtag_req_t         jtag_o
);

  localparam int unsigned NumSync = NumMio + NumDio;

  // Pins handed to the TAP
  localparam logic [NumDio-1:0] JtagPinMask = (NumDio'(1) << DioSpiDevD0)  |
                                              (NumDio'(1) << DioSpiDevD1)  |
                                              (NumDio'(1) << DioSpiDevCsb) |
                                              (NumDio'(1) << DioSpiDevSck);

  logic               jtag_active;
  logic               usb_diff;
  logic [NumDio-1:0]  dio_pre;
  logic [NumDio-1:0]  dio_sync;
  logic [NumSync-1:0] sync1_q;
  logic [NumSync-1:0] sync2_q;

  assign jtag_active = strap_i.valid & (strap_i.tap != TapNone);

  //////////////////////////////
  // USB receive and sync
  //////////////////////////////

  // Differential receiver model
  assign usb_diff = usb_rx_en_i & dio_pad_i[DioUsbP] & ~dio_pad_i[DioUsbN];

  always_comb begin
    dio_pre          = dio_ring_i;
    dio_pre[DioUsbD] = usb_diff; // Raw D pad is not used
  end

  always_ff @(posedge clk_main_i) begin
    if (rst_i) begin
      sync1_q <= '0;
      sync2_q <= '0;
    end else begin
      sync1_q <= {dio_pre, mio_ring_i};
      sync2_q <= sync1_q;
    end
  end

  assign mio_sync_o = sync2_q[NumMio-1:0];
  assign mio_in_o   = sync2_q[NumMio-1:0];
  assign dio_sync   = sync2_q[NumSync-1:NumMio];

  // Core sees fixed values on the TAP pins
  assign dio_in_o = jtag_active ? ((dio_sync & ~JtagPinMask) | JtagTieOff) : dio_sync;

  //////////////////////////////
  // JTAG and pull-ups
  //////////////////////////////

  always_comb begin
    dio_out_o = dio_out_i;
    dio_oe_o  = dio_oe_i;
    if (jtag_active) begin
      dio_out_o[DioSpiDevD1] = jtag_tdo_i; // TDO takes the pad
      dio_oe_o[DioSpiDevD1]  = 1'b1;
    end
  end

  always_comb begin
    jtag_o = '0;
    if (jtag_active) begin
      jtag_o.tck    = dio_pad_i[DioSpiDevSck];
      jtag_o.tms    = dio_pad_i[DioSpiDevCsb];
      jtag_o.tdi    = dio_pad_i[DioSpiDevD0];
      jtag_o.trst_n = mio_ring_i[TrstIdx];
    end
  end

  assign usb_pullup_dp_o = dio_out_i[DioUsbDpPullup] & dio_oe_i[DioUsbDpPullup];
  assign usb_pullup_dn_o = dio_out_i[DioUsbDnPullup] & dio_oe_i[DioUsbDnPullup];

endmodule : io_overlay

`default_nettype wire

/* hw/chip_pad_top.sv */
//////////////////////////////
// Chip pad frame top level
//////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module chip_pad_top
  import pad_pkg::*;
  import pinout_pkg::*;
#(
  parameter int unsigned NumMio = DefaultNumMio
) (
  input  logic                    clk_main_i,
  input  logic                    rst_i,
  // Core side
  input  logic       [NumMio-1:0] mio_out_i,
  input  logic       [NumMio-1:0] mio_oe_i,
  input  logic       [NumDio-1:0] dio_out_i,
  input  logic       [NumDio-1:0] dio_oe_i,
  input  pad_attr_t  [NumMio-1:0] mio_attr_i,
  input  pad_attr_t  [NumDio-1:0] dio_attr_i,
  output logic       [NumMio-1:0] mio_in_o,
  output logic       [NumDio-1:0] dio_in_o,
  // Pad side
  input  logic       [NumMio-1:0] mio_pad_i,
  input  logic       [NumDio-1:0] dio_pad_i,
  output pad_drive_t [NumMio-1:0] mio_pad_o,
  output pad_drive_t [NumDio-1:0] dio_pad_o,
  // USB, JTAG, straps
  input  logic                    usb_rx_en_i,
  output logic                    usb_pullup_dp_o,
  output logic                    usb_pullup_dn_o,
  output jtag_req_t               jtag_o,
  input  logic                    jtag_tdo_i,
  output strap_t                  strap_o
);

  typedef pad_variant_e [NumMio-1:0] mio_variant_t;
  typedef pad_variant_e [NumDio-1:0] dio_variant_t;

  // MIO 8-9 tolerant, 10-11 open drain, rest bidir
  function automatic mio_variant_t mio_variants();
    mio_variant_t v;
    for (int i = 0; i < NumMio; i++) begin
      if (i == 10 || i == 11) begin
        v[i] = PadOpenDrain;
      end else if (i == 8 || i == 9) begin
        v[i] = PadTolerant;
      end else begin
        v[i] = PadBidir;
      end
    end
    return v;
  endfunction

  function automatic dio_variant_t dio_variants();
    dio_variant_t v;
    v               = '{default: PadBidir};
    v[DioSpiDevSck] = PadInputOnly;
    v[DioSpiDevCsb] = PadInputOnly;
    v[DioUsbP]      = PadTolerant;
    v[DioUsbN]      = PadTolerant;
    return v;
  endfunction

  localparam mio_variant_t MioPadVariant = mio_variants();
  localparam dio_variant_t DioPadVariant = dio_variants();

  logic [NumDio-1:0] dio_out_ring;
  logic [NumDio-1:0] dio_oe_ring;
  logic [NumMio-1:0] mio_in_ring;
  logic [NumDio-1:0] dio_in_ring;
  logic [NumMio-1:0] mio_sync;

  padring #(
    .NumMio        ( NumMio        ),
    .MioPadVariant ( MioPadVariant ),
    .DioPadVariant ( DioPadVariant )
  ) padring_inst (
    .mio_out_i  ( mio_out_i    ),
    .mio_oe_i   ( mio_oe_i     ),
    .mio_attr_i ( mio_attr_i   ),
    .mio_pad_i  ( mio_pad_i    ),
    .mio_pad_o  ( mio_pad_o    ),
    .mio_in_o   ( mio_in_ring  ),
    .dio_out_i  ( dio_out_ring ), // After TDO override
    .dio_oe_i   ( dio_oe_ring  ),
    .dio_attr_i ( dio_attr_i   ),
    .dio_pad_i  ( dio_pad_i    ),
    .dio_pad_o  ( dio_pad_o    ),
    .dio_in_o   ( dio_in_ring  )
  );

  io_overlay #(
    .NumMio ( NumMio )
  ) io_overlay_inst (
    .clk_main_i      ( clk_main_i      ),
    .rst_i           ( rst_i           ),
    .dio_out_i       ( dio_out_i       ),
    .dio_oe_i        ( dio_oe_i        ),
    .mio_ring_i      ( mio_in_ring     ),
    .dio_ring_i      ( dio_in_ring     ),
    .dio_pad_i       ( dio_pad_i       ),
    .strap_i         ( strap_o         ),
    .usb_rx_en_i     ( usb_rx_en_i     ),
    .jtag_tdo_i      ( jtag_tdo_i      ),
    .dio_out_o       ( dio_out_ring    ),
    .dio_oe_o        ( dio_oe_ring     ),
    .mio_in_o        ( mio_in_o        ),
    .dio_in_o        ( dio_in_o        ),
    .mio_sync_o      ( mio_sync        ),
    .usb_pullup_dp_o ( usb_pullup_dp_o ),
    .usb_pullup_dn_o ( usb_pullup_dn_o ),
    .jtag_o          ( jtag_o          )
  );

  strap_sampler #(
    .NumMio ( NumMio )
  ) strap_sampler_inst (
    .clk_main_i ( clk_main_i ),
    .rst_i      ( rst_i      ),
    .mio_sync_i ( mio_sync   ),
    .strap_o    ( strap_o    )
  );

endmodule : chip_pad_top

`default_nettype wire

/* testbench/chip_pad_props.sv */
//////////////////////////////
// Bound checks on straps and input-only pads
//////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module chip_pad_props
  import pad_pkg::*;
  import pinout_pkg::*;
(
  input logic                    clk_main_i,
  input logic                    rst_i,
  input strap_t                  strap_i,
  input pad_drive_t [NumDio-1:0] dio_drive_i
);

  // Straps cleared by the reset edge
  strap_clear_in_reset : assert property (@(posedge clk_main_i) rst_i |=> !strap_i.valid)
    else $error("strap valid set during reset");

  // Captured straps never move
  strap_hold : assert property (@(posedge clk_main_i) disable iff (rst_i)
    strap_i.valid |=> (!strap_i.valid || $stable(strap_i)))
    else $error("strap value changed while valid");

  input_only_no_drive : assert property (@(posedge clk_main_i)
    !dio_drive_i[DioSpiDevSck].oe && !dio_drive_i[DioSpiDevCsb].oe)
    else $error("input-only pad has its enable set");

endmodule : chip_pad_props

bind chip_pad_top chip_pad_props chip_pad_props_inst (
  .clk_main_i  ( clk_main_i ),
  .rst_i       ( rst_i      ),
  .strap_i     ( strap_o    ),
  .dio_drive_i ( dio_pad_o  )
);

`default_nettype wire

/* testbench/tb_chip_pad.sv */
//////////////////////////////
// Testbench for the chip pad frame
// Directed tests for pad drive, input sync, straps, JTAG and USB
//////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module tb_chip_pad
  import pad_pkg::*;
  import pinout_pkg::*;
();

  localparam int unsigned NumMio        = DefaultNumMio;
  localparam int          ClkPeriod     = 4;
  localparam int          ResetCycles   = 8;
  localparam int          SyncDelay     = 2;
  localparam int          NumTests      = 5;
  localparam int          MaxTestCycles = 100;

  // DIO pins owned by the TAP, and what the core sees on them
  localparam logic [NumDio-1:0] JtagPins  = (NumDio'(1) << DioSpiDevD0)  |
                                            (NumDio'(1) << DioSpiDevD1)  |
                                            (NumDio'(1) << DioSpiDevCsb) |
                                            (NumDio'(1) << DioSpiDevSck);
  localparam logic [NumDio-1:0] TieOffExp = NumDio'(1) << DioSpiDevCsb;
  localparam logic [NumDio-1:0] InputMask = ~(NumDio'(1) << DioUsbD); // USB D is replaced

  logic                    clk_main_i;
  logic                    rst_i;
  logic       [NumMio-1:0] mio_out_i;
  logic       [NumMio-1:0] mio_oe_i;
  logic       [NumDio-1:0] dio_out_i;
  logic       [NumDio-1:0] dio_oe_i;
  pad_attr_t  [NumMio-1:0] mio_attr_i;
  pad_attr_t  [NumDio-1:0] dio_attr_i;
  logic       [NumMio-1:0] mio_in_o;
  logic       [NumDio-1:0] dio_in_o;
  logic       [NumMio-1:0] mio_pad_i;
  logic       [NumDio-1:0] dio_pad_i;
  pad_drive_t [NumMio-1:0] mio_pad_o;
  pad_drive_t [NumDio-1:0] dio_pad_o;
  logic                    usb_rx_en_i;
  logic                    usb_pullup_dp_o;
  logic                    usb_pullup_dn_o;
  jtag_req_t               jtag_o;
  logic                    jtag_tdo_i;
  strap_t                  strap_o;

  chip_pad_top chip_pad_top_inst (
    .clk_main_i      ( clk_main_i      ),
    .rst_i           ( rst_i           ),
    .mio_out_i       ( mio_out_i       ),
    .mio_oe_i        ( mio_oe_i        ),
    .dio_out_i       ( dio_out_i       ),
    .dio_oe_i        ( dio_oe_i        ),
    .mio_attr_i      ( mio_attr_i      ),
    .dio_attr_i      ( dio_attr_i      ),
    .mio_in_o        ( mio_in_o        ),
    .dio_in_o        ( dio_in_o        ),
    .mio_pad_i       ( mio_pad_i       ),
    .dio_pad_i       ( dio_pad_i       ),
    .mio_pad_o       ( mio_pad_o       ),
    .dio_pad_o       ( dio_pad_o       ),
    .usb_rx_en_i     ( usb_rx_en_i     ),
    .usb_pullup_dp_o ( usb_pullup_dp_o ),
    .usb_pullup_dn_o ( usb_pullup_dn_o ),
    .jtag_o          ( jtag_o          ),
    .jtag_tdo_i      ( jtag_tdo_i      ),
    .strap_o         ( strap_o         )
  );

  initial begin
    clk_main_i = 1'b0;
    forever #(ClkPeriod / 2) clk_main_i = ~clk_main_i;
  end

  initial begin // Watchdog
    #(NumTests * MaxTestCycles * ClkPeriod);
    $display("Watchdog expired before all tests finished");
    fail_run();
  end

  //////////////////////////////
  // Reporting and reference model
  //////////////////////////////

  task automatic fail_run();
    $display("Done: errors found");
    $fatal(1, "Stopped at first failure");
  endtask

  task automatic mismatch(input string msg);
    $display("Mismatch at %0d ns: %s", $time, msg);
    fail_run();
  endtask

  function automatic pad_variant_e mio_kind(input int idx);
    if (idx >= 10) return PadOpenDrain;
    if (idx >= 8) return PadTolerant;
    return PadBidir;
  endfunction

  function automatic pad_variant_e dio_kind(input int idx);
    if (idx == DioSpiDevSck || idx == DioSpiDevCsb) return PadInputOnly;
    if (idx == DioUsbP || idx == DioUsbN) return PadTolerant;
    return PadBidir;
  endfunction

  function automatic pad_drive_t expect_drive(input pad_variant_e kind, input logic out,
                                              input logic oe, input pad_attr_t attr);
    pad_drive_t d;
    d.out     = out ^ attr.invert;
    d.oe      = oe;
    if (attr.virt_od_en && d.out) d.oe = 1'b0;
    if (kind == PadOpenDrain && d.out) d.oe = 1'b0;
    if (kind == PadInputOnly) d.oe = 1'b0;
    d.pull_en = attr.pull_en;
    d.pull_up = attr.pull_up;
    return d;
  endfunction

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge clk_main_i);
  endtask

  task automatic randomize_core();
    mio_out_i = NumMio'($urandom);
    mio_oe_i  = NumMio'($urandom);
    dio_out_i = NumDio'($urandom);
    dio_oe_i  = NumDio'($urandom);
    for (int i = 0; i < NumMio; i++) mio_attr_i[i] = pad_attr_t'(4'($urandom));
    for (int i = 0; i < NumDio; i++) dio_attr_i[i] = pad_attr_t'(4'($urandom));
  endtask

  // Reset with given strap levels, then check the capture on the third edge
  task automatic reset_with_straps(input tap_sel_e tap, input logic [1:0] dft);
    logic [1:0] tap_bits;
    tap_bits = tap;
    @(negedge clk_main_i);
    rst_i                   = 1'b1;
    mio_attr_i              = '0;
    mio_pad_i[TapStrap1Idx] = tap_bits[1];
    mio_pad_i[TapStrap0Idx] = tap_bits[0];
    mio_pad_i[DftStrap1Idx] = dft[1];
    mio_pad_i[DftStrap0Idx] = dft[0];
    repeat (ResetCycles) begin
      @(negedge clk_main_i);
      assert (strap_o == '0) else mismatch("strap_o not cleared during reset");
    end
    rst_i = 1'b0;
    wait_cycles(2);
    assert (!strap_o.valid) else mismatch("strap_o.valid rose before the third edge");
    wait_cycles(1);
    assert (strap_o.valid && strap_o.tap == tap && strap_o.dft == dft)
      else mismatch($sformatf("strap_o %b, expected tap %b dft %b", strap_o, tap, dft));
  endtask

  //////////////////////////////
  // Directed tests
  //////////////////////////////

  task automatic test_output_resolution();
    pad_drive_t exp;
    reset_with_straps(TapNone, 2'b00);
    for (int n = 0; n < 40; n++) begin
      @(negedge clk_main_i);
      randomize_core();
      #1; // Drive path is combinational
      for (int i = 0; i < NumMio; i++) begin
        exp = expect_drive(mio_kind(i), mio_out_i[i], mio_oe_i[i], mio_attr_i[i]);
        assert (mio_pad_o[i] == exp)
          else mismatch($sformatf("MIO %0d drive %b, expected %b", i, mio_pad_o[i], exp));
      end
      for (int i = 0; i < NumDio; i++) begin
        exp = expect_drive(dio_kind(i), dio_out_i[i], dio_oe_i[i], dio_attr_i[i]);
        assert (dio_pad_o[i] == exp)
          else mismatch($sformatf("DIO %0d drive %b, expected %b", i, dio_pad_o[i], exp));
      end
    end
  endtask

  task automatic test_input_path();
    logic [NumMio-1:0] exp_mio;
    logic [NumDio-1:0] exp_dio;
    logic [NumMio-1:0] prev_mio;
    logic [NumDio-1:0] prev_dio;
    @(negedge clk_main_i);
    mio_pad_i  = '0;
    dio_pad_i  = '0;
    mio_attr_i = '0;
    dio_attr_i = '0;
    exp_mio    = '0;
    exp_dio    = '0;
    wait_cycles(SyncDelay);
    for (int n = 0; n < 32; n++) begin
      prev_mio  = exp_mio;
      prev_dio  = exp_dio;
      mio_pad_i = NumMio'($urandom);
      dio_pad_i = NumDio'($urandom);
      for (int i = 0; i < NumMio; i++) mio_attr_i[i] = pad_attr_t'(4'($urandom));
      for (int i = 0; i < NumDio; i++) dio_attr_i[i] = pad_attr_t'(4'($urandom));
      for (int i = 0; i < NumMio; i++) exp_mio[i] = mio_pad_i[i] ^ mio_attr_i[i].invert;
      for (int i = 0; i < NumDio; i++) exp_dio[i] = dio_pad_i[i] ^ dio_attr_i[i].invert;
      wait_cycles(1); // Old value still at the output
      assert (mio_in_o == prev_mio && (dio_in_o & InputMask) == (prev_dio & InputMask))
        else mismatch($sformatf("inputs changed after one edge, mio %h dio %h", mio_in_o,
                                dio_in_o));
      wait_cycles(1);
      assert (mio_in_o == exp_mio)
        else mismatch($sformatf("mio_in_o %h, expected %h", mio_in_o, exp_mio));
      assert ((dio_in_o & InputMask) == (exp_dio & InputMask))
        else mismatch($sformatf("dio_in_o %h, expected %h", dio_in_o, exp_dio));
    end
  endtask

  task automatic test_strap_sampling();
    tap_sel_e   tap;
    logic [1:0] dft;
    strap_t     held;
    for (int r = 0; r < 2; r++) begin
      tap = tap_sel_e'(2'($urandom));
      dft = 2'($urandom);
      reset_with_straps(tap, dft);
      held = strap_o;
      for (int n = 0; n < 10; n++) begin
        mio_pad_i = NumMio'($urandom); // Straps move after capture
        wait_cycles(1);
        assert (strap_o == held)
          else mismatch($sformatf("strap_o %b moved, captured %b", strap_o, held));
      end
    end
  endtask

  task automatic test_jtag_overlay();
    reset_with_straps(TapRv, 2'b00);
    dio_attr_i = '0;
    for (int n = 0; n < 16; n++) begin
      dio_pad_i          = NumDio'($urandom);
      mio_pad_i[TrstIdx] = 1'($urandom);
      jtag_tdo_i         = 1'($urandom);
      dio_out_i          = NumDio'($urandom);
      dio_oe_i           = '0;
      #1;
      assert (jtag_o.tck == dio_pad_i[DioSpiDevSck] && jtag_o.tms == dio_pad_i[DioSpiDevCsb] &&
              jtag_o.tdi == dio_pad_i[DioSpiDevD0] && jtag_o.trst_n == mio_pad_i[TrstIdx])
        else mismatch($sformatf("jtag_o %b does not follow the pads", jtag_o));
      assert (dio_pad_o[DioSpiDevD1].out == jtag_tdo_i && dio_pad_o[DioSpiDevD1].oe)
        else mismatch($sformatf("TDO pad drive %b, tdo %b", dio_pad_o[DioSpiDevD1], jtag_tdo_i));
      wait_cycles(SyncDelay);
      assert ((dio_in_o & JtagPins) == TieOffExp)
        else mismatch($sformatf("JTAG core inputs %b, expected %b", dio_in_o & JtagPins,
                                TieOffExp));
    end
    reset_with_straps(TapNone, 2'b00);
    for (int n = 0; n < 8; n++) begin
      dio_pad_i  = NumDio'($urandom);
      jtag_tdo_i = 1'($urandom);
      dio_out_i  = NumDio'($urandom);
      dio_oe_i   = NumDio'($urandom);
      #1;
      assert (jtag_o == '0) else mismatch($sformatf("jtag_o %b with no TAP", jtag_o));
      assert (dio_pad_o[DioSpiDevD1].out == dio_out_i[DioSpiDevD1] &&
              dio_pad_o[DioSpiDevD1].oe == dio_oe_i[DioSpiDevD1])
        else mismatch("TDO pad not under core control");
      wait_cycles(1);
    end
  endtask

  task automatic test_usb_overlay();
    logic exp_d;
    for (int n = 0; n < 24; n++) begin
      randomize_core();
      dio_pad_i   = NumDio'($urandom);
      usb_rx_en_i = 1'($urandom);
      #1;
      assert (usb_pullup_dp_o == (dio_out_i[DioUsbDpPullup] & dio_oe_i[DioUsbDpPullup]) &&
              usb_pullup_dn_o == (dio_out_i[DioUsbDnPullup] & dio_oe_i[DioUsbDnPullup]))
        else mismatch($sformatf("pull-ups dp %b dn %b", usb_pullup_dp_o, usb_pullup_dn_o));
      exp_d = usb_rx_en_i & dio_pad_i[DioUsbP] & ~dio_pad_i[DioUsbN]; // Raw pads, no invert
      wait_cycles(SyncDelay);
      assert (dio_in_o[DioUsbD] == exp_d)
        else mismatch($sformatf("USB D in %b, expected %b", dio_in_o[DioUsbD], exp_d));
    end
  endtask

  initial begin
    void'($urandom(23209));
    rst_i       = 1'b1;
    mio_out_i   = '0;
    mio_oe_i    = '0;
    dio_out_i   = '0;
    dio_oe_i    = '0;
    mio_attr_i  = '0;
    dio_attr_i  = '0;
    mio_pad_i   = '0;
    dio_pad_i   = '0;
    usb_rx_en_i = 1'b0;
    jtag_tdo_i  = 1'b0;
    test_output_resolution();
    test_input_path();
    test_strap_sampling();
    test_jtag_overlay();
    test_usb_overlay();
    $display("Done: no errors");
    $finish;
  end

endmodule : tb_chip_pad

`default_nettype wire

/* compile.f */
hw/pad_pkg.sv
hw/pinout_pkg.sv
hw/pad_cell.sv
hw/padring.sv
hw/strap_sampler.sv
hw/io_overlay.sv
hw/chip_pad_top.sv
testbench/chip_pad_props.sv
testbench/tb_chip_pad.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the pad frame testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_chip_pad -f compile.f \
  --Mdir obj_dir -o sim_chip_pad

# A failing run returns nonzero, so keep going and judge by the output
sim_out=$(./obj_dir/sim_chip_pad 2>&1) || true
echo "$sim_out"

if echo "$sim_out" | grep -q "^Done: no errors$"; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi
